// ==== src.f ====
verilog/rv_pkg.sv
verilog/reg_file.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/writeback_stage.sv
verilog/riscv_core.sv
verif/riscv_core_props.sv
verif/riscv_core_tb.sv

// ==== Makefile ====
SOURCES := $(shell cat src.f)
BIN := obj_dir/Vriscv_core_tb

.PHONY: all run clean

all: run

$(BIN): src.f $(SOURCES)
	verilator --binary --timing --assert --top-module riscv_core_tb -f src.f

run: $(BIN)
	./$(BIN) | tee sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== verif/riscv_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module riscv_core_tb import rv_pkg::*; ();

  localparam word_t START_PC    = 32'h0000_0100;
  localparam int    PROG_LEN    = 15;
  localparam int    DRAIN       = 3;
  localparam int    TIMEOUT_NS  = (PROG_LEN + 12) * 8;
  localparam insn_t NOP         = 32'h0000_0013;
  localparam insn_t ECALL       = 32'h0000_0073;

  logic          clk;
  logic          rst;
  word_t         pc;
  insn_t         insn;
  logic          halt;
  word_t         trace_pc;
  insn_t         trace_insn;
  cycle_status_e trace_status;
  reg_write_t    trace_write;

  insn_t prog     [PROG_LEN];
  logic  exp_we   [PROG_LEN];
  word_t exp_data [PROG_LEN];
  int    ecall_idx;
  int    errors;
  word_t last_pc;

  riscv_core #(
    .RESET_PC (START_PC)
  ) u_riscv_core (
    .clk          (clk),
    .rst          (rst),
    .pc           (pc),
    .insn         (insn),
    .halt         (halt),
    .trace_pc     (trace_pc),
    .trace_insn   (trace_insn),
    .trace_status (trace_status),
    .trace_write  (trace_write)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  function automatic insn_t lui_word(input reg_idx_t rd, input logic [19:0] imm);
    return {imm, rd, 7'h37};
  endfunction

  function automatic insn_t addi_word(input reg_idx_t rd, input reg_idx_t rs1,
                                     input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, 7'h13};
  endfunction

  function automatic insn_t add_word(input reg_idx_t rd, input reg_idx_t rs1,
                                    input reg_idx_t rs2);
    return {7'b0000000, rs2, rs1, 3'b000, rd, 7'h33};
  endfunction

  // program entry or a nop past the end
  function automatic insn_t table_insn(input int idx);
    if (idx >= 0 && idx < PROG_LEN) begin
      return prog[idx];
    end
    return NOP;
  endfunction

  // reference register model applied in program order
  function automatic void build_expected();
    word_t    regs [32];
    insn_t    w;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    value;
    logic     writes;
    for (int r = 0; r < 32; r++) begin
      regs[r] = '0;
    end
    ecall_idx = PROG_LEN;
    for (int i = 0; i < PROG_LEN; i++) begin
      w      = prog[i];
      rd     = w[11:7];
      rs1    = w[19:15];
      rs2    = w[24:20];
      value  = '0;
      writes = 1'b0;
      case (w[6:0])
        7'h37: begin
          value  = {w[31:12], 12'h000};
          writes = 1'b1;
        end
        7'h13: begin
          if (w[14:12] == 3'b000) begin
            value  = regs[rs1] + {{20{w[31]}}, w[31:20]};
            writes = 1'b1;
          end
        end
        7'h33: begin
          if (w[14:12] == 3'b000 && w[31:25] == 7'b0000000) begin
            value  = regs[rs1] + regs[rs2];
            writes = 1'b1;
          end
        end
        default: begin
          if (w == ECALL && ecall_idx == PROG_LEN) begin
            ecall_idx = i;
          end
        end
      endcase
      exp_we[i]   = writes && rd != 5'd0;
      exp_data[i] = value;
      if (exp_we[i]) begin
        regs[rd] = value;
      end
    end
  endfunction

  task automatic check_word(input string name, input word_t actual, input word_t expected);
    assert (actual === expected) else begin
      errors++;
      $display("** Error: %s = %h, expected %h at %0t", name, actual, expected, $time);
    end
  endtask

  task automatic check_cycle(input int cyc);
    int    idx;
    logic  we_exp;
    insn_t w;
    idx = cyc - 4;
    check_word("pc", pc, START_PC + word_t'(4 * cyc));
    if (cyc < 4) begin
      check_word("trace_status", word_t'(trace_status), word_t'(CYCLE_RESET));
      check_word("trace_write.we", word_t'(trace_write.we), 32'd0);
      check_word("halt", word_t'(halt), 32'd0);
    end else begin
      w      = table_insn(idx);
      we_exp = 1'b0;
      if (idx < PROG_LEN) begin
        we_exp = exp_we[idx];
      end
      check_word("trace_pc", trace_pc, START_PC + word_t'(4 * idx));
      if (cyc > 4) begin
        check_word("trace_pc step", trace_pc - last_pc, 32'd4);
      end
      check_word("trace_insn", trace_insn, w);
      check_word("trace_status", word_t'(trace_status), word_t'(CYCLE_NO_STALL));
      check_word("trace_write.we", word_t'(trace_write.we), word_t'(we_exp));
      if (we_exp) begin
        check_word("trace_write.rd", word_t'(trace_write.rd), word_t'(w[11:7]));
        check_word("trace_write.data", trace_write.data, exp_data[idx]);
      end
      // halt follows the ecall and then holds
      check_word("halt", word_t'(halt), word_t'(idx >= ecall_idx));
      last_pc = trace_pc;
    end
  endtask

  // instruction port served a little after each edge
  always @(posedge clk) begin
    #1;
    insn = table_insn(int'((pc - START_PC) >> 2));
  end

  initial begin
    #(TIMEOUT_NS);
    $display("watchdog expired before the program drained through writeback");
    $display("Test failed");
    $finish;
  end

  initial begin
    rst     = 1'b1;
    insn    = NOP;
    errors  = 0;
    last_pc = '0;
    prog[0]  = lui_word(5'd1, 20'h12345);
    // distance 1 on x1 through the mx bypass
    prog[1]  = addi_word(5'd1, 5'd1, 12'h678);
    prog[2]  = addi_word(5'd2, 5'd0, 12'hffb);
    // x1 at distance 2 and x2 at distance 1
    prog[3]  = add_word(5'd3, 5'd1, 5'd2);
    prog[4]  = addi_word(5'd4, 5'd0, 12'd100);
    prog[5]  = addi_word(5'd5, 5'd0, 12'd7);
    prog[6]  = addi_word(5'd0, 5'd5, 12'd123);
    // x4 at distance 3 through the register file
    prog[7]  = add_word(5'd7, 5'd4, 5'd5);
    prog[8]  = add_word(5'd8, 5'd0, 5'd7);
    prog[9]  = addi_word(5'd9, 5'd8, 12'h800);
    prog[10] = lui_word(5'd10, 20'hfffff);
    prog[11] = add_word(5'd10, 5'd10, 5'd10);
    prog[12] = addi_word(5'd11, 5'd10, 12'h7ff);
    prog[13] = ECALL;
    prog[14] = add_word(5'd12, 5'd11, 5'd3);
    build_expected();

    repeat (2) @(posedge clk);
    #1 rst = 1'b0;
    #1;
    for (int cyc = 0; cyc < 4 + PROG_LEN + DRAIN; cyc++) begin
      check_cycle(cyc);
      @(posedge clk);
      #2;
    end

    $display("checks finished with %0d error(s)", errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verif/riscv_core_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module riscv_core_props import rv_pkg::*; (
  input logic          clk,
  input logic          rst,
  input logic          halt,
  input cycle_status_e trace_status,
  input reg_write_t    trace_write
);

  // every writeback cycle is classified once out of reset
  assert property (@(posedge clk) disable iff (rst) trace_status != CYCLE_INVALID)
    else $error("trace status is invalid outside reset");

  // writes to x0 are filtered in execute
  assert property (@(posedge clk) disable iff (rst) trace_write.we |-> trace_write.rd != 5'd0)
    else $error("register write request targets x0");

  // halt is sticky until reset
  assert property (@(posedge clk) disable iff (rst) halt |=> halt)
    else $error("halt dropped without a reset");

endmodule

bind riscv_core riscv_core_props u_riscv_core_props (
  .clk          (clk),
  .rst          (rst),
  .halt         (halt),
  .trace_status (trace_status),
  .trace_write  (trace_write)
);

`default_nettype wire

// ==== verilog/riscv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module riscv_core import rv_pkg::*; #(
  parameter word_t RESET_PC = '0
) (
  input  logic          clk,
  input  logic          rst,
  output word_t         pc,
  input  insn_t         insn,
  output logic          halt,
  output word_t         trace_pc,
  output insn_t         trace_insn,
  output cycle_status_e trace_status,
  output reg_write_t    trace_write
);

  stage_decode_t  decode_state;
  stage_execute_t execute_state;
  stage_memory_t  memory_state;
  reg_write_t     rf_write;

  fetch_stage #(
    .RESET_PC (RESET_PC)
  ) u_fetch_stage (
    .clk          (clk),
    .rst          (rst),
    .pc           (pc),
    .insn         (insn),
    .decode_state (decode_state)
  );

  decode_stage u_decode_stage (
    .clk           (clk),
    .rst           (rst),
    .decode_state  (decode_state),
    .rf_write      (rf_write),
    .execute_state (execute_state)
  );

  // rf_write also feeds the wx bypass here
  execute_stage u_execute_stage (
    .clk           (clk),
    .rst           (rst),
    .execute_state (execute_state),
    .rf_write      (rf_write),
    .memory_state  (memory_state)
  );

  writeback_stage u_writeback_stage (
    .clk          (clk),
    .rst          (rst),
    .memory_state (memory_state),
    .rf_write     (rf_write),
    .trace_pc     (trace_pc),
    .trace_insn   (trace_insn),
    .trace_status (trace_status),
    .halt         (halt)
  );

  // trace of the register write in the writeback cycle
  assign trace_write = rf_write;

endmodule

`default_nettype wire

// ==== verilog/writeback_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module writeback_stage import rv_pkg::*; (
  input  logic          clk,
  input  logic          rst,
  input  stage_memory_t memory_state,
  output reg_write_t    rf_write,
  output word_t         trace_pc,
  output insn_t         trace_insn,
  output cycle_status_e trace_status,
  output logic          halt
);

  stage_memory_t wb_state;
  logic          halt_q;
  logic          ecall_now;

  // memory stage does nothing, so this register is the last pipeline step
  always_ff @(posedge clk) begin
    if (rst) begin
      wb_state <= '{pc: '0, insn: '0, result: '0, we: 1'b0, status: CYCLE_RESET};
    end else begin
      wb_state <= memory_state;
    end
  end

  // register write and wx bypass source
  assign rf_write.we   = wb_state.we;
  assign rf_write.rd   = wb_state.insn[11:7];
  assign rf_write.data = wb_state.result;

  assign trace_pc     = wb_state.pc;
  assign trace_insn   = wb_state.insn;
  assign trace_status = wb_state.status;

  // halt shows in the same cycle the ecall is in writeback
  assign ecall_now = wb_state.insn == INSN_ECALL;
  assign halt      = halt_q | ecall_now;

  // sticky until the next reset
  always_ff @(posedge clk) begin
    if (rst) begin
      halt_q <= 1'b0;
    end else begin
      halt_q <= halt;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_stage import rv_pkg::*; (
  input  logic           clk,
  input  logic           rst,
  input  stage_execute_t execute_state,
  input  reg_write_t     rf_write,
  output stage_memory_t  memory_state
);

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_idx_t   rd;
  reg_idx_t   rs1;
  reg_idx_t   rs2;
  word_t      imm_i;
  word_t      op_a;
  word_t      op_b;
  word_t      result;
  logic       is_lui;
  logic       is_addi;
  logic       is_add;
  logic       writes_rd;

  assign opcode = opcode_e'(execute_state.insn[6:0]);
  assign rd     = execute_state.insn[11:7];
  assign funct3 = execute_state.insn[14:12];
  assign rs1    = execute_state.insn[19:15];
  assign rs2    = execute_state.insn[24:20];
  assign funct7 = execute_state.insn[31:25];
  assign imm_i  = {{20{execute_state.insn[31]}}, execute_state.insn[31:20]};

  // the nearer producer wins, memory before writeback
  function automatic word_t forward(
    input reg_idx_t      src,
    input word_t         decoded,
    input stage_memory_t mem,
    input reg_write_t    wb
  );
    word_t value;
    if (mem.we && mem.insn[11:7] == src) begin
      value = mem.result;
    end else if (wb.we && wb.rd == src) begin
      value = wb.data;
    end else begin
      value = decoded;
    end
    return value;
  endfunction

  always_comb begin
    op_a = forward(rs1, execute_state.a, memory_state, rf_write);
    op_b = forward(rs2, execute_state.b, memory_state, rf_write);
  end

  assign is_lui  = opcode == OP_LUI;
  assign is_addi = opcode == OP_REG_IMM && funct3 == FUNCT3_ADD;
  assign is_add  = opcode == OP_REG_REG && funct3 == FUNCT3_ADD && funct7 == FUNCT7_ADD;

  always_comb begin
    result = '0;
    if (is_lui) begin
      result = {execute_state.insn[31:12], 12'd0};
    end else if (is_addi) begin
      result = op_a + imm_i;
    end else if (is_add) begin
      result = op_a + op_b;
    end
  end

  // decided once here, writeback only copies it
  assign writes_rd = (is_lui || is_addi || is_add) && rd != '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      memory_state <= '{pc: '0, insn: '0, result: '0, we: 1'b0, status: CYCLE_RESET};
    end else begin
      memory_state <= '{
        pc:     execute_state.pc,
        insn:   execute_state.insn,
        result: result,
        we:     writes_rd,
        status: execute_state.status
      };
    end
  end

endmodule

`default_nettype wire

// ==== verilog/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage import rv_pkg::*; (
  input  logic           clk,
  input  logic           rst,
  input  stage_decode_t  decode_state,
  input  reg_write_t     rf_write,
  output stage_execute_t execute_state
);

  reg_idx_t rs1;
  reg_idx_t rs2;
  word_t    rs1_data;
  word_t    rs2_data;

  // source fields sit at the same place in every format
  assign rs1 = decode_state.insn[19:15];
  assign rs2 = decode_state.insn[24:20];

  // writes from writeback land here and pass through to the reads
  reg_file u_reg_file (
    .clk      (clk),
    .rst      (rst),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .write    (rf_write)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      execute_state <= '{
        pc:     '0,
        insn:   '0,
        a:      '0,
        b:      '0,
        status: CYCLE_RESET
      };
    end else begin
      execute_state <= '{
        pc:     decode_state.pc,
        insn:   decode_state.insn,
        a:      rs1_data,
        b:      rs2_data,
        status: decode_state.status
      };
    end
  end

endmodule

`default_nettype wire

// ==== verilog/fetch_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_stage import rv_pkg::*; #(
  parameter word_t RESET_PC = '0
) (
  input  logic          clk,
  input  logic          rst,
  output word_t         pc,
  input  insn_t         insn,
  output stage_decode_t decode_state
);

  // straight-line fetch, no redirects
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= RESET_PC;
    end else begin
      pc <= pc + 32'd4;
    end
  end

  // insn arrives from the port in the same cycle as pc
  always_ff @(posedge clk) begin
    if (rst) begin
      decode_state <= '{pc: '0, insn: '0, status: CYCLE_RESET};
    end else begin
      decode_state <= '{pc: pc, insn: insn, status: CYCLE_NO_STALL};
    end
  end

endmodule

`default_nettype wire

// ==== verilog/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file import rv_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  reg_idx_t   rs1,
  input  reg_idx_t   rs2,
  output word_t      rs1_data,
  output word_t      rs2_data,
  input  reg_write_t write
);

  // x0 has no storage
  word_t regs [1:31];

  // a read of the register being written returns the new value
  function automatic word_t read_port(input reg_idx_t idx);
    word_t value;
    if (idx == '0) begin
      value = '0;
    end else if (write.we && write.rd == idx) begin
      value = write.data;
    end else begin
      value = regs[idx];
    end
    return value;
  endfunction

  always_comb begin
    rs1_data = read_port(rs1);
    rs2_data = read_port(rs2);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (write.we && write.rd != '0) begin
      regs[write.rd] <= write.data;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

  // architectural widths
  typedef logic [31:0] word_t;
  typedef logic [31:0] insn_t;
  typedef logic [4:0]  reg_idx_t;

  // major opcodes this core decodes, anything else is unsupported
  typedef enum logic [6:0] {
    OP_LUI     = 7'b0110111,
    OP_REG_IMM = 7'b0010011,
    OP_REG_REG = 7'b0110011,
    OP_ENVIRON = 7'b1110011
  } opcode_e;

  // classification of the cycle seen in writeback
  typedef enum logic [2:0] {
    CYCLE_INVALID  = 3'd0,
    CYCLE_RESET    = 3'd1,
    CYCLE_NO_STALL = 3'd2
  } cycle_status_e;

  // funct fields for ADDI and ADD
  localparam logic [2:0] FUNCT3_ADD = 3'b000;
  localparam logic [6:0] FUNCT7_ADD = 7'b0000000;

  // ecall is the all-zero environment instruction
  localparam insn_t INSN_ECALL = {25'd0, OP_ENVIRON};

  typedef struct packed {
    word_t         pc;
    insn_t         insn;
    cycle_status_e status;
  } stage_decode_t;

  typedef struct packed {
    word_t         pc;
    insn_t         insn;
    word_t         a;
    word_t         b;
    cycle_status_e status;
  } stage_execute_t;

  typedef struct packed {
    word_t         pc;
    insn_t         insn;
    word_t         result;
    logic          we;
    cycle_status_e status;
  } stage_memory_t;

  // register file write request, also the wx bypass source
  typedef struct packed {
    logic     we;
    reg_idx_t rd;
    word_t    data;
  } reg_write_t;

endpackage

`default_nettype wire
